// File: tb.f
+incdir+.
hisPkg.sv
hisRam.sv
hisBuilder.sv
hisTop.sv
tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the histogram testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb -f tb.f -o tbSim

./obj_dir/tbSim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation reported errors"
    exit 1
fi

echo "simulation finished without errors"
exit 0

// File: tb.sv
`timescale 1ns/1ps

`include "sifh_params.svh"

module tb;

    import hisPkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int CLEAR_CYC   = `RAM_DEPTH;
    localparam int SCAN_CYC    = `PIXEL_NUM * (`BIN_NUM + 1);
    localparam int ACQ_NUM     = 5;     // acquisitions over all tests
    localparam int SAMPLE_CYC  = 2600;  // sample and gap cycles of all tests
    localparam int TIMEOUT_CYC = 2 * (ACQ_NUM * (CLEAR_CYC + SCAN_CYC) + SAMPLE_CYC);

    logic  clk;
    logic  res;
    logic  start;
    logic  sampleValid;
    pixelT samplePixel;
    binT   sampleBin;
    logic  acqDone;
    logic  ready;
    logic  peakValid;
    pixelT peakPixel;
    binT   peakBin;
    countT peakCount;
    logic  hisBuildDone;

    countT refCnt [`PIXEL_NUM][`BIN_NUM];  // expected histograms
    countT peakSeen [`PIXEL_NUM];          // peak counts reported by the DUT
    pixelT qPixel [$];
    binT   qBin [$];
    int    qGap [$];

    int cycleCnt = 0;
    int errCnt = 0;
    int testErrStart = 0;
    int testCnt = 0;
    int testsBad = 0;

    hisTop hisTop_inst (
        .clk          (clk),
        .res          (res),
        .start        (start),
        .sampleValid  (sampleValid),
        .samplePixel  (samplePixel),
        .sampleBin    (sampleBin),
        .acqDone      (acqDone),
        .ready        (ready),
        .peakValid    (peakValid),
        .peakPixel    (peakPixel),
        .peakBin      (peakBin),
        .peakCount    (peakCount),
        .hisBuildDone (hisBuildDone)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= TIMEOUT_CYC) begin
            $display("Error: run timed out after %0d cycles", cycleCnt);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic stepCycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic reportError(input string msg);
        $display("Error: %s", msg);
        errCnt++;
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errCnt++;
        end
    endtask

    task automatic checkPixel(input string name, input pixelT got, input pixelT exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errCnt++;
        end
    endtask

    task automatic checkBin(input string name, input binT got, input binT exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errCnt++;
        end
    endtask

    task automatic checkCount(input string name, input countT got, input countT exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errCnt++;
        end
    endtask

    task automatic clearModel();
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            for (int b = 0; b < `BIN_NUM; b++) begin
                refCnt[p][b] = '0;
            end
        end
    endtask

    // first bin holding the largest count
    function automatic binT refPeakBin(input int p);
        binT   bestBin;
        countT best;
        bestBin = '0;
        best    = refCnt[p][0];
        for (int b = 1; b < `BIN_NUM; b++) begin
            if (refCnt[p][b] > best) begin
                best    = refCnt[p][b];
                bestBin = binT'(b);
            end
        end
        return bestBin;
    endfunction

    task automatic queueRun(input int p, input int b, input int n, input int gap);
        for (int i = 0; i < n; i++) begin
            qPixel.push_back(pixelT'(p));
            qBin.push_back(binT'(b));
            qGap.push_back(gap);
        end
    endtask

    task automatic queueFlush();
        qPixel.delete();
        qBin.delete();
        qGap.delete();
    endtask

    // a sample only counts while ready is high
    task automatic driveSample(input pixelT p, input binT b);
        sampleValid = 1'b1;
        samplePixel = p;
        sampleBin   = b;
        if (ready && refCnt[p][b] != '1) begin
            refCnt[p][b] = countT'(refCnt[p][b] + 1);
        end
    endtask

    task automatic driveNoise(input bit noisy);
        sampleValid = 1'b0;
        if (noisy && ($urandom % 2) == 1) begin
            driveSample(pixelT'($urandom % `PIXEL_NUM), binT'($urandom % `BIN_NUM));
        end
    endtask

    task automatic runAcq(input bit noisy, input bit doneWithLast);
        int waited;
        int peakNum;
        int lastPeak;
        int last;
        bit doneSeen;
        clearModel();  // start clears the RAM
        start = 1'b1;
        stepCycle();
        start  = 1'b0;
        waited = 0;
        while (!ready && waited < CLEAR_CYC + 8) begin
            driveNoise(noisy);
            stepCycle();
            waited++;
        end
        sampleValid = 1'b0;
        if (!ready) begin
            reportError("ready did not rise after the clear phase");
            return;
        end

        last = qPixel.size() - 1;
        for (int i = 0; i <= last; i++) begin
            driveSample(qPixel[i], qBin[i]);
            if (noisy && i == last / 2) begin
                start = 1'b1;  // ignored outside IDLE
            end
            if (doneWithLast && i == last) begin
                acqDone = 1'b1;
            end
            stepCycle();
            sampleValid = 1'b0;
            start       = 1'b0;
            acqDone     = 1'b0;
            repeat (qGap[i]) stepCycle();
        end
        if (!doneWithLast || last < 0) begin
            acqDone = 1'b1;
            stepCycle();
            acqDone = 1'b0;
        end

        // collect the peaks
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            peakSeen[p] = '0;
        end
        waited   = 0;
        peakNum  = 0;
        lastPeak = -2;
        doneSeen = 1'b0;
        while (!doneSeen && waited < 2 * SCAN_CYC + 16) begin
            if (peakValid) begin
                if (peakNum < `PIXEL_NUM) begin
                    checkPixel("peakPixel", peakPixel, pixelT'(peakNum));
                    checkBin("peakBin", peakBin, refPeakBin(peakNum));
                    checkCount("peakCount", peakCount, refCnt[peakNum][refPeakBin(peakNum)]);
                    peakSeen[peakNum] = peakCount;
                end
                lastPeak = waited;
                peakNum++;
            end
            if (hisBuildDone) begin
                doneSeen = 1'b1;
                if (waited != lastPeak + 1) begin
                    reportError("hisBuildDone did not follow the last peak by one cycle");
                end
            end
            driveNoise(noisy);
            stepCycle();
            waited++;
        end
        sampleValid = 1'b0;
        if (peakNum != `PIXEL_NUM) begin
            reportError($sformatf("saw %0d peak pulses instead of %0d", peakNum, `PIXEL_NUM));
        end
        if (!doneSeen) begin
            reportError("hisBuildDone never pulsed after the scan");
        end
    endtask

    task automatic endTest(input string name);
        testCnt++;
        if (errCnt == testErrStart) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errCnt - testErrStart);
            testsBad++;
        end
        testErrStart = errCnt;
    endtask

    task automatic testReset();
        repeat (8) begin
            checkFlag("ready", ready, 1'b0);
            checkFlag("peakValid", peakValid, 1'b0);
            checkFlag("hisBuildDone", hisBuildDone, 1'b0);
            stepCycle();
        end
        endTest("reset");
    endtask

    task automatic testEmpty();
        queueFlush();
        runAcq(1'b0, 1'b0);
        endTest("empty");
    endtask

    task automatic testPeaks();
        queueFlush();
        queueRun(0, 5, 3, 1);
        queueRun(0, 2, 1, 1);
        queueRun(0, 9, 2, 1);
        queueRun(1, 12, 4, 1);
        queueRun(1, 0, 2, 1);
        queueRun(2, 7, 3, 1);  // ties with bin 3 so the lower bin wins
        queueRun(2, 3, 3, 1);
        queueRun(2, 10, 1, 1);
        queueRun(3, 15, 2, 1);
        queueRun(3, 1, 1, 1);
        runAcq(1'b0, 1'b1);
        endTest("peaks");
    endtask

    task automatic testForward();
        queueFlush();
        queueRun(1, 6, 40, 0);  // back to back into one word
        for (int k = 0; k < 30; k++) begin
            queueRun(2, 4, 1, 0);
            queueRun(2, 5, 1, 0);
        end
        for (int k = 0; k < 25; k++) begin
            queueRun(0, 1, 1, 0);
            queueRun(3, 1, 1, 0);
        end
        runAcq(1'b0, 1'b1);
        endTest("forward");
    endtask

    task automatic testSaturate();
        queueFlush();
        queueRun(2, 11, 300, 0);
        queueRun(2, 0, 10, 0);
        runAcq(1'b0, 1'b0);
        checkCount("peakCount", peakSeen[2], 8'hff);  // 300 hits stop at the top
        endTest("saturate");
    endtask

    task automatic testRandom();
        int gap;
        queueFlush();
        for (int i = 0; i < 500; i++) begin
            gap = (($urandom % 4) == 0) ? int'($urandom % 4) : 0;
            queueRun(int'($urandom % `PIXEL_NUM), int'($urandom % `BIN_NUM), 1, gap);
        end
        runAcq(1'b1, 1'b0);
        endTest("random");
    endtask

    initial begin
        void'($urandom(32'h8941_3631));
        res         = 1'b0;
        start       = 1'b0;
        sampleValid = 1'b0;
        samplePixel = '0;
        sampleBin   = '0;
        acqDone     = 1'b0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        res = 1'b1;

        testReset();
        testEmpty();
        testPeaks();
        testForward();
        testSaturate();
        testRandom();

        $display("tests %0d, with errors %0d, total errors %0d", testCnt, testsBad, errCnt);
        if (errCnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: hisTop.sv
`timescale 1ns/1ps

`include "sifh_params.svh"

module hisTop (
    input  logic          clk,
    input  logic          res,

    // acquisition control
    input  logic          start,
    input  logic          acqDone,
    output logic          ready,

    // timestamped hits
    input  logic          sampleValid,
    input  hisPkg::pixelT samplePixel,
    input  hisPkg::binT   sampleBin,

    // per-pixel peaks
    output logic          peakValid,
    output hisPkg::pixelT peakPixel,
    output hisPkg::binT   peakBin,
    output hisPkg::countT peakCount,
    output logic          hisBuildDone
);

    import hisPkg::*;

    // builder to RAM
    logic    wEnable;
    ramAddrT waddr;
    countT   wdata;
    logic    rEnable;
    ramAddrT raddr;
    countT   rdata;

    hisBuilder hisBuilder_inst (
        .clk          (clk),
        .res          (res),
        .start        (start),
        .sampleValid  (sampleValid),
        .samplePixel  (samplePixel),
        .sampleBin    (sampleBin),
        .acqDone      (acqDone),
        .ready        (ready),
        .wEnable      (wEnable),
        .waddr        (waddr),
        .wdata        (wdata),
        .rEnable      (rEnable),
        .raddr        (raddr),
        .rdata        (rdata),
        .peakValid    (peakValid),
        .peakPixel    (peakPixel),
        .peakBin      (peakBin),
        .peakCount    (peakCount),
        .hisBuildDone (hisBuildDone)
    );

    // one counter per pixel and bin
    hisRam #(
        .DEPTH (`RAM_DEPTH),
        .WIDTH (`CNT_W)
    ) hisRam_inst (
        .clk     (clk),
        .wEnable (wEnable),
        .waddr   (waddr),
        .wdata   (wdata),
        .rEnable (rEnable),
        .raddr   (raddr),
        .rdata   (rdata)
    );

endmodule

// File: hisBuilder.sv
`timescale 1ns/1ps

`include "sifh_params.svh"

module hisBuilder (
    input  logic            clk,
    input  logic            res,

    // control and samples
    input  logic            start,
    input  logic            sampleValid,
    input  hisPkg::pixelT   samplePixel,
    input  hisPkg::binT     sampleBin,
    input  logic            acqDone,
    output logic            ready,

    // RAM write port
    output logic            wEnable,
    output hisPkg::ramAddrT waddr,
    output hisPkg::countT   wdata,

    // RAM read port
    output logic            rEnable,
    output hisPkg::ramAddrT raddr,
    input  hisPkg::countT   rdata,

    // peak results
    output logic            peakValid,
    output hisPkg::pixelT   peakPixel,
    output hisPkg::binT     peakBin,
    output hisPkg::countT   peakCount,
    output logic            hisBuildDone
);

    import hisPkg::*;

    builderStateT state;
    builderStateT nextState;

    ramAddrT addrCnt;       // clear and scan address
    logic    drainCnt;
    logic    scanGap;       // bubble after each pixel's last read
    logic    scanRead;
    logic    lastRead;      // bin bits of addrCnt at the top

    // read-modify-write pipeline
    logic    accept;
    logic    s1Valid;       // read stage
    ramAddrT s1Addr;
    logic    s2Valid;       // write stage
    ramAddrT s2Addr;
    logic    lastWValid;    // previous cycle's write
    ramAddrT lastWAddr;
    countT   lastWData;
    countT   operand;
    countT   incCount;

    // peak search
    logic    rdValid;
    ramAddrT rdAddr;
    binT     rdBin;
    logic    lastBin;
    countT   curMax;
    binT     curBin;
    logic    takeNew;
    countT   candCount;
    binT     candBin;

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (start) begin
                    nextState = CLEAR;
                end
            end
            CLEAR: begin
                if (addrCnt == ramAddrT'(`RAM_DEPTH - 1)) begin
                    nextState = ACCUM;
                end
            end
            ACCUM: begin
                if (acqDone) begin
                    nextState = DRAIN;
                end
            end
            DRAIN: begin
                if (drainCnt) begin  // second drain cycle
                    nextState = SCAN;
                end
            end
            SCAN: begin
                // addrCnt has wrapped once the last pixel is read
                if (scanGap && addrCnt == '0) begin
                    nextState = DONE;
                end
            end
            DONE: begin
                nextState = IDLE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    assign ready    = (state == ACCUM);
    assign accept   = sampleValid && ready;
    assign scanRead = (state == SCAN) && !scanGap;
    assign lastRead = (addrCnt[`BIN_W-1:0] == '1);

    // the RAM returns stale data when the previous sample wrote this word
    assign operand  = (lastWValid && lastWAddr == s2Addr) ? lastWData : rdata;
    assign incCount = (operand == '1) ? operand : operand + 1'b1;  // saturate

    // clear and accumulation never overlap
    assign wEnable = (state == CLEAR) || s2Valid;
    assign waddr   = s2Valid ? s2Addr : addrCnt;
    assign wdata   = s2Valid ? incCount : '0;

    // sample reads and scan reads are in different phases too
    assign rEnable = s1Valid || scanRead;
    assign raddr   = s1Valid ? s1Addr : addrCnt;

    // running maximum, strict compare keeps the lowest bin on a tie
    assign rdBin     = binT'(rdAddr[`BIN_W-1:0]);
    assign lastBin   = (rdBin == binT'(`BIN_NUM - 1));
    assign takeNew   = (rdBin == '0) || (rdata > curMax);  // bin 0 restarts the search
    assign candCount = takeNew ? rdata : curMax;
    assign candBin   = takeNew ? rdBin : curBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state        <= IDLE;
            addrCnt      <= '0;
            drainCnt     <= 1'b0;
            scanGap      <= 1'b0;
            s1Valid      <= 1'b0;
            s2Valid      <= 1'b0;
            lastWValid   <= 1'b0;
            rdValid      <= 1'b0;
            peakValid    <= 1'b0;
            hisBuildDone <= 1'b0;
        end else begin
            state <= nextState;

            if (state == CLEAR || scanRead) begin
                addrCnt <= addrCnt + 1'b1;  // wraps to 0 at the end
            end else if (state != SCAN) begin
                addrCnt <= '0;
            end

            drainCnt <= (state == DRAIN) && !drainCnt;
            scanGap  <= scanRead && lastRead;

            s1Valid    <= accept;
            s2Valid    <= s1Valid;
            lastWValid <= wEnable;

            rdValid      <= scanRead;
            peakValid    <= rdValid && lastBin;  // last bin of a pixel is back
            hisBuildDone <= (state == DONE);
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        s1Addr    <= {samplePixel, sampleBin};
        s2Addr    <= s1Addr;
        lastWAddr <= waddr;
        lastWData <= wdata;
        rdAddr    <= addrCnt;

        if (rdValid) begin
            curMax <= candCount;
            curBin <= candBin;
        end

        if (rdValid && lastBin) begin
            peakPixel <= pixelT'(rdAddr[`RAM_ADDR_W-1:`BIN_W]);
            peakBin   <= candBin;
            peakCount <= candCount;
        end
    end

endmodule

// File: hisRam.sv
`timescale 1ns/1ps

module hisRam #(
    parameter int DEPTH = 64,
    parameter int WIDTH = 8,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk,

    // write port
    input  logic              wEnable,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [WIDTH-1:0]  wdata,

    // read port
    input  logic              rEnable,
    input  logic [ADDR_W-1:0] raddr,
    output logic [WIDTH-1:0]  rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wEnable) begin
            mem[waddr] <= wdata;
        end
    end

    // one cycle read latency
    // a same-cycle write to raddr is not seen here
    always_ff @(posedge clk) begin
        if (rEnable) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: hisPkg.sv
`include "sifh_params.svh"

package hisPkg;

    typedef logic [`PIXEL_W-1:0]    pixelT;     // pixel index
    typedef logic [`BIN_W-1:0]      binT;       // bin index inside one histogram
    typedef logic [`RAM_ADDR_W-1:0] ramAddrT;   // {pixel, bin}
    typedef logic [`CNT_W-1:0]      countT;     // saturating bin counter

    // histogram builder controller
    typedef enum logic [2:0] {
        IDLE,   // waiting for start
        CLEAR,  // zero every RAM word
        ACCUM,  // taking samples
        DRAIN,  // rmw pipeline empties
        SCAN,   // peak search over all pixels
        DONE    // last peak out
    } builderStateT;

endpackage

// File: sifh_params.svh
`ifndef SIFH_PARAMS_SVH
`define SIFH_PARAMS_SVH

// pixel array geometry
`define PIXEL_NUM   4
`define PIXEL_W     2

// bins per pixel histogram
`define BIN_NUM     16
`define BIN_W       4

// bin counter, saturates at all ones
`define CNT_W       8

// one word per pixel and bin
// address is {pixel, bin}
`define RAM_DEPTH   (`PIXEL_NUM * `BIN_NUM)
`define RAM_ADDR_W  (`PIXEL_W + `BIN_W)

`endif
